//--- lb_pkg.sv
// shared sizes, pixel/window/mask types and position classes for the 3x3 window generator
`default_nettype none

package lb_pkg;

  localparam int PIX_W    = 16;        // bits per pixel
  localparam int WIN      = 3;         // window side
  localparam int WIN_TAPS = WIN * WIN; // taps per window
  localparam int LINE_MAX = 64;        // longest line, power of two for pointer wrap
  localparam int CNT_W    = 16;        // counter and width field size
  localparam int ADDR_W   = $clog2(LINE_MAX); // line delay address bits

  typedef logic [PIX_W-1:0] pixel_t;

  // tap 0 is top-left (two rows up, two cols left)
  // tap 8 is bottom-right, the pixel being accepted
  // taps run row by row
  typedef pixel_t [WIN_TAPS-1:0] window_t;

  typedef logic [WIN_TAPS-1:0] mask_t; // 1 keeps the tap

  typedef logic [CNT_W-1:0] cnt_t; // line position or width

  // position class of the current pixel
  // row 0 / row 1 / row 2+ crossed with col 0 / col 1 / col 2+
  typedef enum logic [3:0] {
    rim_r0c0,
    rim_r0c1,
    rim_r0cn,
    rim_r1c0,
    rim_r1c1,
    rim_r1cn,
    rim_rnc0,
    rim_rnc1,
    rim_rncn
  } rim_e;

endpackage

`default_nettype wire

//--- pix_stream_if.sv
// valid/ready pixel stream from the top-level input into the line store
`timescale 1ns/1ps
`default_nettype none

interface pix_stream_if;
  import lb_pkg::*;

  logic   valid;  // beat present
  logic   ready;  // sink can take it
  pixel_t pixel;  // one pixel, raster order
  logic   last;   // final pixel of the frame

  // source holds pixel and last while stalled
  modport src (
    output valid,
    output pixel,
    output last,
    input  ready
  );

  modport snk (
    input  valid,
    input  pixel,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

//--- win_stream_if.sv
// valid/ready window stream carrying assembled 3x3 windows and their position class to the gate
`timescale 1ns/1ps
`default_nettype none

interface win_stream_if;
  import lb_pkg::*;

  logic    valid;   // follows the pixel stream combinationally
  logic    ready;   // from the output gate
  window_t window;  // taps for the pixel on the bus
  rim_e    rim;     // where that pixel sits in the frame
  logic    last;    // frame end marker, passed through

  // line_store side
  modport src (
    output valid,
    output window,
    output rim,
    output last,
    input  ready
  );

  // window_gate side
  // beat is taken only when valid seen with ready high
  modport snk (
    input  valid,
    input  window,
    input  rim,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

//--- raster_counter.sv
// column/row counters for accepted pixels, giving the position class of the pixel being accepted
`timescale 1ns/1ps
`default_nettype none

module raster_counter (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          accept,     // beat transfers this edge
  input  logic          last,       // frame end on this beat
  input  lb_pkg::cnt_t  cfg_width,  // pixels per line
  output lb_pkg::rim_e  rim         // class of current pixel
);
  import lb_pkg::*;

  cnt_t       col;      // column of the pixel on the bus
  cnt_t       row;      // row of the pixel on the bus, saturates
  logic       col_end;  // this pixel closes its line
  logic [1:0] row_cls;  // 0, 1 or 2+
  logic [1:0] col_cls;

  assign col_end = (col == cfg_width - cnt_t'(1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      col <= '0;
      row <= '0;
    end
    else if (accept)
    begin
      if (last)
      begin
        col <= '0;  // next frame starts at origin
        row <= '0;
      end
      else if (col_end)
      begin
        col <= '0;
        if (row != '1)
          row <= row + cnt_t'(1);  // only 0/1/2+ matter, so stick at top
      end
      else
        col <= col + cnt_t'(1);
    end
  end

  assign row_cls = (row == '0) ? 2'd0 : (row == cnt_t'(1)) ? 2'd1 : 2'd2;
  assign col_cls = (col == '0) ? 2'd0 : (col == cnt_t'(1)) ? 2'd1 : 2'd2;

  always_comb
  begin
    case ({row_cls, col_cls})
      4'b00_00: rim = rim_r0c0;
      4'b00_01: rim = rim_r0c1;
      4'b00_10: rim = rim_r0cn;
      4'b01_00: rim = rim_r1c0;
      4'b01_01: rim = rim_r1c1;
      4'b01_10: rim = rim_r1cn;
      4'b10_00: rim = rim_rnc0;
      4'b10_01: rim = rim_rnc1;
      default:  rim = rim_rncn;  // row 2+, col 2+
    endcase
  end

endmodule

`default_nettype wire

//--- line_store.sv
// two line delays and the 3x3 window registers, assembling the window for each incoming pixel
`timescale 1ns/1ps
`default_nettype none

module line_store (
  input  logic          clk,
  input  logic          rst_n,
  input  lb_pkg::cnt_t  cfg_width,  // line length, 3..LINE_MAX
  pix_stream_if.snk     pix,
  win_stream_if.src     win
);
  import lb_pkg::*;

  logic              accept;                         // pixel beat transfers
  logic [ADDR_W-1:0] wr_ptr;                         // shared by both delays
  logic [ADDR_W-1:0] rd_ptr;                         // trails wr_ptr by one line
  pixel_t            line_mem [WIN-1][LINE_MAX];     // [0] one line back, [1] two lines back
  pixel_t            line_in  [WIN-1];
  pixel_t            line_out [WIN-1];
  pixel_t            col_in   [WIN];                 // newest column, top to bottom
  pixel_t            win_reg  [WIN][WIN-1];          // two older columns per row
  window_t           window_asm;

  // handshake straight through, the gate decides ready
  assign pix.ready = win.ready;
  assign win.valid = pix.valid;
  assign win.last  = pix.last;
  assign accept    = pix.valid & pix.ready;

  // LINE_MAX wide width truncates to 0 so read and write slots coincide
  // read happens before the write lands, so that still gives the old line
  assign rd_ptr = wr_ptr - cfg_width[ADDR_W-1:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_ptr <= '0;
    else if (accept)
      wr_ptr <= wr_ptr + 1'b1;  // wraps at LINE_MAX
  end

  // delays chained: pixel into [0], output of [0] into [1]
  assign line_in[0] = pix.pixel;
  assign line_in[1] = line_out[0];

  always_comb
  begin
    for (int k = 0; k < WIN-1; k++)
      line_out[k] = line_mem[k][rd_ptr];
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      for (int k = 0; k < WIN-1; k++)
        line_mem[k][wr_ptr] <= line_in[k];
  end

  assign col_in[0] = line_out[1];  // two rows up
  assign col_in[1] = line_out[0];  // one row up
  assign col_in[2] = pix.pixel;    // current row

  // shift each row left by one column per accept
  always_ff @(posedge clk)
  begin
    if (accept)
      for (int i = 0; i < WIN; i++)
      begin
        for (int j = 0; j < WIN-2; j++)
          win_reg[i][j] <= win_reg[i][j+1];
        win_reg[i][WIN-2] <= col_in[i];
      end
  end

  always_comb
  begin
    for (int i = 0; i < WIN; i++)
    begin
      for (int j = 0; j < WIN-1; j++)
        window_asm[i*WIN+j] = win_reg[i][j];
      window_asm[i*WIN+WIN-1] = col_in[i];  // right column is live
    end
  end

  assign win.window = window_asm;

  raster_counter u_raster_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept    (accept),
    .last      (pix.last),
    .cfg_width (cfg_width),
    .rim       (win.rim)
  );

endmodule

`default_nettype wire

//--- window_gate.sv
// masks padded taps, drops windows reaching outside the image, and holds the one-entry output
`timescale 1ns/1ps
`default_nettype none

module window_gate (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             pad_en,      // zero-pad edges instead of dropping
  win_stream_if.snk        win,
  output logic             out_valid,
  input  logic             out_ready,
  output lb_pkg::window_t  out_window,
  output logic             out_last
);
  import lb_pkg::*;

  mask_t   mask;        // per-tap keep bits for this class
  window_t masked;
  logic    keep;        // beat produces an output window
  logic    take;        // beat consumed this edge

  // bit 8 is the current pixel, bits 2..0 the top tap row
  // row 0 clears two top rows, row 1 the top row
  // col 0 clears two left columns, col 1 the left column
  always_comb
  begin
    case (win.rim)
      rim_r0c0: mask = 9'b100_000_000;
      rim_r0c1: mask = 9'b110_000_000;
      rim_r0cn: mask = 9'b111_000_000;
      rim_r1c0: mask = 9'b100_100_000;
      rim_r1c1: mask = 9'b110_110_000;
      rim_r1cn: mask = 9'b111_111_000;
      rim_rnc0: mask = 9'b100_100_100;
      rim_rnc1: mask = 9'b110_110_110;
      rim_rncn: mask = 9'b111_111_111;
      default:  mask = '0;
    endcase
  end

  // without padding only rncn survives and its mask is all ones
  always_comb
  begin
    for (int t = 0; t < WIN_TAPS; t++)
      masked[t] = mask[t] ? win.window[t] : '0;
  end

  assign keep = pad_en | (win.rim == rim_rncn);

  // slot free, or being emptied this cycle
  assign win.ready = ~out_valid | out_ready;
  assign take      = win.valid & win.ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else if (take && keep)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;  // drained, dropped beats leave it empty
  end

  always_ff @(posedge clk)
  begin
    if (take && keep)
    begin
      out_window <= masked;
      out_last   <= win.last;
    end
  end

endmodule

`default_nettype wire

//--- line_window_top.sv
// top level of the streaming 3x3 window generator with plain stream ports
`timescale 1ns/1ps
`default_nettype none

module line_window_top (
  input  logic             clk,
  input  logic             rst_n,
  input  lb_pkg::cnt_t     cfg_width,   // change only between frames
  input  logic             pad_en,      // same
  input  logic             in_valid,
  output logic             in_ready,
  input  lb_pkg::pixel_t   in_pixel,
  input  logic             in_last,
  output logic             out_valid,
  input  logic             out_ready,
  output lb_pkg::window_t  out_window,
  output logic             out_last
);

  pix_stream_if u_pix ();
  win_stream_if u_win ();

  // input side of the pixel stream
  assign u_pix.valid = in_valid;
  assign u_pix.pixel = in_pixel;
  assign u_pix.last  = in_last;
  assign in_ready    = u_pix.ready;  // not out_valid, or out_ready

  line_store u_line_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_width (cfg_width),
    .pix       (u_pix),
    .win       (u_win)
  );

  // one window held at the output
  window_gate u_window_gate (
    .clk        (clk),
    .rst_n      (rst_n),
    .pad_en     (pad_en),
    .win        (u_win),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_window (out_window),
    .out_last   (out_last)
  );

endmodule

`default_nettype wire

//--- tb_line_window_chk.sv
// output handshake assertions for the window generator, bound into its top level
`timescale 1ns/1ps
`default_nettype none

module tb_line_window_chk (
  input logic            clk,
  input logic            rst_n,
  input logic            in_ready,
  input logic            out_valid,
  input logic            out_ready,
  input lb_pkg::window_t out_window,
  input logic            out_last
);

  int fail_cnt = 0;  // failed properties so far

  // first edge out of reset sees an empty output
  a_reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
    else
    begin
      fail_cnt++;
      $error("out_valid high in first cycle after reset");
    end

  // stalled window must not move
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_window) && $stable(out_last))
    else
    begin
      fail_cnt++;
      $error("output changed while stalled");
    end

  a_ready: assert property (@(posedge clk) disable iff (!rst_n) !out_valid |-> in_ready)
    else
    begin
      fail_cnt++;
      $error("in_ready low with empty output");
    end

  a_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_window))
    else
    begin
      fail_cnt++;
      $error("out_window has unknown bits while valid");
    end

endmodule

bind line_window_top tb_line_window_chk u_chk (.*);

`default_nettype wire

//--- tb_line_window.sv
// directed testbench for the 3x3 window generator; compile with the bound checker, top tb_line_window
`timescale 1ns/1ps
`default_nettype none

module tb_line_window;
  import lb_pkg::*;

  localparam int TOTAL_PIX   = 30 + 30 + 32 + 9 + LINE_MAX * 3;  // pixels over all tests
  localparam int CYCLE_LIMIT = 4 * TOTAL_PIX + 200;

  logic    clk;
  logic    rst_n;
  cnt_t    cfg_width;
  logic    pad_en;
  logic    in_valid;
  logic    in_ready;
  pixel_t  in_pixel;
  logic    in_last;
  logic    out_valid;
  logic    out_ready;
  window_t out_window;
  logic    out_last;

  integer  seed   = 32'h6f09_b4b8;
  int      cycle  = 0;             // rising edges since start
  int      errors = 0;
  int      checks = 0;
  int      tests  = 0;
  pixel_t  frame [LINE_MAX*5];     // current frame in raster order
  window_t got_win  [$];           // monitor output in order
  logic    got_last [$];
  int      got_cyc  [$];           // cycle of each output transfer
  int      acc_cyc  [$];           // cycle of each pixel accept

  line_window_top u_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  // hang guard
  initial
  begin
    while (cycle < CYCLE_LIMIT)
      @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  // sample mid-cycle where everything has settled
  // the transfer lands on the next edge
  always @(negedge clk)
  begin
    if (in_valid && in_ready)
      acc_cyc.push_back(cycle);
    if (out_valid && out_ready)
    begin
      got_win.push_back(out_window);
      got_last.push_back(out_last);
      got_cyc.push_back(cycle);
    end
  end

  task automatic compare_window(input string name, input window_t exp, input window_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_last(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // tap (i,j) of pixel (r,c) is pixel (r-2+i, c-2+j) or zero outside the image
  function automatic window_t model_window(input int width, input int r, input int c);
    window_t w;
    int      rr;
    int      cc;
    for (int i = 0; i < WIN; i++)
      for (int j = 0; j < WIN; j++)
      begin
        rr = r - 2 + i;
        cc = c - 2 + j;
        w[i*WIN+j] = (rr < 0 || cc < 0) ? pixel_t'(0) : frame[rr*width+cc];
      end
    return w;
  endfunction

  // one edge and then inputs move 10 ns later
  task automatic next_cycle(input logic stall);
    @(posedge clk);
    #10;
    out_ready = stall ? (($random(seed) & 1) != 0) : 1'b1;
  endtask

  // sends one frame, drains the output, then checks list, last flags and latency
  task automatic run_frame(input string name, input int width, input int height,
                           input logic pad, input logic stall);
    window_t exp_win  [$];
    logic    exp_last [$];
    int      exp_idx  [$];   // source pixel of each expected window
    int      n;
    int      err_before;
    logic    hs;
    n = width * height;
    err_before = errors;
    got_win.delete();
    got_last.delete();
    got_cyc.delete();
    acc_cyc.delete();
    for (int k = 0; k < n; k++)
      frame[k] = pixel_t'($random(seed));
    for (int r = 0; r < height; r++)
      for (int c = 0; c < width; c++)
        if (pad || (r >= 2 && c >= 2))  // unpadded keeps interior only
        begin
          exp_win.push_back(model_window(width, r, c));
          exp_last.push_back(r == height - 1 && c == width - 1);
          exp_idx.push_back(r * width + c);
        end
    cfg_width = cnt_t'(width);  // output is empty here between frames
    pad_en    = pad;
    for (int k = 0; k < n; k++)
    begin
      in_valid = 1'b1;
      in_pixel = frame[k];
      in_last  = (k == n - 1);
      hs = 1'b0;
      while (!hs)
      begin
        @(negedge clk);
        hs = in_ready;  // held until taken
        next_cycle(stall);
      end
    end
    in_valid = 1'b0;
    in_last  = 1'b0;
    @(negedge clk);
    while (out_valid)
    begin
      next_cycle(stall);
      @(negedge clk);
    end
    next_cycle(1'b0);
    compare_count("window count", exp_win.size(), got_win.size());
    for (int k = 0; k < exp_win.size() && k < got_win.size(); k++)
    begin
      compare_window("out_window", exp_win[k], got_win[k]);
      compare_last("out_last", exp_last[k], got_last[k]);
      if (!stall && exp_idx[k] < acc_cyc.size())
        compare_count("out_valid latency", acc_cyc[exp_idx[k]] + 1, got_cyc[k]);
    end
    tests++;
    $display("test %s: %s, %0d windows", name, (errors == err_before) ? "ok" : "failed",
             got_win.size());
  endtask

  initial
  begin
    rst_n     = 1'b0;
    cfg_width = cnt_t'(6);
    pad_en    = 1'b0;
    in_valid  = 1'b0;
    in_pixel  = '0;
    in_last   = 1'b0;
    out_ready = 1'b1;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;
    next_cycle(1'b0);
    run_frame("no padding", 6, 5, 1'b0, 1'b0);
    run_frame("padding", 6, 5, 1'b1, 1'b0);
    run_frame("back-pressure", 8, 4, 1'b1, 1'b1);
    run_frame("narrow line", 3, 3, 1'b0, 1'b0);   // counters cleared by last
    run_frame("full line", LINE_MAX, 3, 1'b0, 1'b0);
    errors += u_dut.u_chk.fail_cnt;  // failed handshake properties
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, u_dut.u_chk.fail_cnt);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
lb_pkg.sv
pix_stream_if.sv
win_stream_if.sv
raster_counter.sv
line_store.sv
window_gate.sv
line_window_top.sv
tb_line_window_chk.sv
tb_line_window.sv

//--- Bender.yml
package:
  name: line_window

sources:
  - lb_pkg.sv
  - pix_stream_if.sv
  - win_stream_if.sv
  - raster_counter.sv
  - line_store.sv
  - window_gate.sv
  - line_window_top.sv
  - target: simulation
    files:
      - tb_line_window_chk.sv
      - tb_line_window.sv
